// File: include/ctrl_config.svh
`ifndef CTRL_CONFIG_SVH
`define CTRL_CONFIG_SVH

// pipeline shape
// if, de, exe, mem, wb
`define CTRL_NUM_STAGES 5
// if/de, de/exe, exe/mem, mem/wb
`define CTRL_NUM_LD 4

// instruction field widths
`define CTRL_OPCODE_W 7
`define CTRL_FUNCT3_W 3
// rd index into the register file
`define CTRL_REG_W 5

`endif

// File: src/ctrl_pkg.sv
`include "ctrl_config.svh"

package ctrl_pkg;

    // rv32i base opcodes
    typedef enum logic [`CTRL_OPCODE_W-1:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_e;

    // alu function, encoding shared with the datapath alu
    typedef enum logic [2:0] {
        alu_add, alu_sll, alu_sra, alu_sub,
        alu_xor, alu_srl, alu_or,  alu_and
    } alu_op_e;

    // comparator op, same values as branch funct3
    typedef enum logic [`CTRL_FUNCT3_W-1:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } cmp_op_e;

    // alu operand a
    typedef enum logic {mux1_rs1_out, mux1_pc_out} alumux1_e;

    // alu operand b
    typedef enum logic [2:0] {
        mux2_i_imm, mux2_u_imm, mux2_b_imm,
        mux2_s_imm, mux2_j_imm, mux2_rs2_out
    } alumux2_e;

    // comparator operand b
    typedef enum logic {cmpmux_rs2_out, cmpmux_i_imm} cmpmux_e;

    // register file write data
    typedef enum logic [3:0] {
        rf_alu_out, rf_br_en, rf_u_imm, rf_lw, rf_pc_plus4,
        rf_lb, rf_lbu, rf_lh, rf_lhu
    } regfilemux_e;

    // kind of control transfer, resolved in exe
    typedef enum logic [1:0] {pc_seq, pc_branch, pc_jal, pc_jalr} pc_kind_e;

    // next pc source
    // alu_mod2 is alu_out with bit 0 cleared, for jalr
    typedef enum logic [1:0] {pcmux_pc_plus4, pcmux_alu_out, pcmux_alu_mod2} pcmux_e;

    // control word staged from de down to wb
    typedef struct packed {
        logic                    valid;
        // exe fields
        alu_op_e                 aluop;
        alumux1_e                alumux1_sel;
        alumux2_e                alumux2_sel;
        cmp_op_e                 cmpop;
        cmpmux_e                 cmp_sel;
        pc_kind_e                pc_kind;
        // mem fields
        logic                    mem_read;
        logic                    mem_write;
        // wb fields
        logic                    ld_reg;
        regfilemux_e             regfilemux_sel;
        logic [`CTRL_REG_W-1:0]  rd_addr;
    } cw_t;

endpackage

// File: src/instr_decoder.sv
`include "ctrl_config.svh"

module instr_decoder (
    input  logic [`CTRL_OPCODE_W-1:0] i_opcode,
    input  logic [`CTRL_FUNCT3_W-1:0] i_funct3,
    input  logic                      i_funct7_b5,
    input  logic [`CTRL_REG_W-1:0]    i_rd_addr,
    input  logic                      i_de_valid,
    input  logic                      i_de_rdy,
    output ctrl_pkg::cw_t             o_cw
);

    always_comb begin
        // idle word, overwritten below for a legal opcode
        o_cw.valid          = 1'b0;
        o_cw.aluop          = ctrl_pkg::alu_add;
        o_cw.alumux1_sel    = ctrl_pkg::mux1_rs1_out;
        o_cw.alumux2_sel    = ctrl_pkg::mux2_i_imm;
        o_cw.cmpop          = ctrl_pkg::beq;
        o_cw.cmp_sel        = ctrl_pkg::cmpmux_rs2_out;
        o_cw.pc_kind        = ctrl_pkg::pc_seq;
        o_cw.mem_read       = 1'b0;
        o_cw.mem_write      = 1'b0;
        o_cw.ld_reg         = 1'b0;
        o_cw.regfilemux_sel = ctrl_pkg::rf_alu_out;
        o_cw.rd_addr        = '0;

        // only decode once de holds a finished instruction
        if (i_de_valid && i_de_rdy) begin
            case (ctrl_pkg::opcode_e'(i_opcode))
                ctrl_pkg::op_lui: begin
                    o_cw.valid          = 1'b1;
                    o_cw.ld_reg         = 1'b1;
                    o_cw.regfilemux_sel = ctrl_pkg::rf_u_imm;
                    o_cw.rd_addr        = i_rd_addr;
                end
                ctrl_pkg::op_auipc: begin
                    o_cw.valid          = 1'b1;
                    o_cw.alumux1_sel    = ctrl_pkg::mux1_pc_out;
                    o_cw.alumux2_sel    = ctrl_pkg::mux2_u_imm;
                    o_cw.ld_reg         = 1'b1;
                    o_cw.rd_addr        = i_rd_addr;
                end
                ctrl_pkg::op_jal: begin
                    // target computed in the alu, link value is pc+4
                    o_cw.valid          = 1'b1;
                    o_cw.alumux1_sel    = ctrl_pkg::mux1_pc_out;
                    o_cw.alumux2_sel    = ctrl_pkg::mux2_j_imm;
                    o_cw.pc_kind        = ctrl_pkg::pc_jal;
                    o_cw.ld_reg         = 1'b1;
                    o_cw.regfilemux_sel = ctrl_pkg::rf_pc_plus4;
                    o_cw.rd_addr        = i_rd_addr;
                end
                ctrl_pkg::op_jalr: begin
                    o_cw.valid          = 1'b1;
                    o_cw.pc_kind        = ctrl_pkg::pc_jalr;
                    o_cw.ld_reg         = 1'b1;
                    o_cw.regfilemux_sel = ctrl_pkg::rf_pc_plus4;
                    o_cw.rd_addr        = i_rd_addr;
                end
                ctrl_pkg::op_br: begin
                    // comparator decides, alu forms pc + b_imm
                    o_cw.valid          = 1'b1;
                    o_cw.cmpop          = ctrl_pkg::cmp_op_e'(i_funct3);
                    o_cw.alumux1_sel    = ctrl_pkg::mux1_pc_out;
                    o_cw.alumux2_sel    = ctrl_pkg::mux2_b_imm;
                    o_cw.pc_kind        = ctrl_pkg::pc_branch;
                end
                ctrl_pkg::op_load: begin
                    o_cw.valid          = 1'b1;
                    o_cw.mem_read       = 1'b1;
                    o_cw.ld_reg         = 1'b1;
                    o_cw.rd_addr        = i_rd_addr;
                    // width and sign extension of the loaded data
                    case (i_funct3)
                        3'd0: o_cw.regfilemux_sel = ctrl_pkg::rf_lb;
                        3'd1: o_cw.regfilemux_sel = ctrl_pkg::rf_lh;
                        3'd2: o_cw.regfilemux_sel = ctrl_pkg::rf_lw;
                        3'd4: o_cw.regfilemux_sel = ctrl_pkg::rf_lbu;
                        3'd5: o_cw.regfilemux_sel = ctrl_pkg::rf_lhu;
                        default: o_cw.regfilemux_sel = ctrl_pkg::rf_lw;
                    endcase
                end
                ctrl_pkg::op_store: begin
                    o_cw.valid          = 1'b1;
                    o_cw.alumux2_sel    = ctrl_pkg::mux2_s_imm;
                    o_cw.mem_write      = 1'b1;
                end
                ctrl_pkg::op_imm, ctrl_pkg::op_reg: begin
                    o_cw.valid          = 1'b1;
                    o_cw.ld_reg         = 1'b1;
                    o_cw.rd_addr        = i_rd_addr;
                    // operand b is the immediate or rs2
                    if (i_opcode == ctrl_pkg::op_reg) begin
                        o_cw.alumux2_sel = ctrl_pkg::mux2_rs2_out;
                        o_cw.cmp_sel     = ctrl_pkg::cmpmux_rs2_out;
                    end else begin
                        o_cw.alumux2_sel = ctrl_pkg::mux2_i_imm;
                        o_cw.cmp_sel     = ctrl_pkg::cmpmux_i_imm;
                    end
                    case (i_funct3)
                        3'd0: begin
                            // sub exists only in the reg form
                            if (i_opcode == ctrl_pkg::op_reg && i_funct7_b5) begin
                                o_cw.aluop = ctrl_pkg::alu_sub;
                            end else begin
                                o_cw.aluop = ctrl_pkg::alu_add;
                            end
                        end
                        3'd1: o_cw.aluop = ctrl_pkg::alu_sll;
                        // slt and sltu go through the comparator
                        3'd2: begin
                            o_cw.cmpop          = ctrl_pkg::blt;
                            o_cw.regfilemux_sel = ctrl_pkg::rf_br_en;
                        end
                        3'd3: begin
                            o_cw.cmpop          = ctrl_pkg::bltu;
                            o_cw.regfilemux_sel = ctrl_pkg::rf_br_en;
                        end
                        3'd4: o_cw.aluop = ctrl_pkg::alu_xor;
                        3'd5: begin
                            if (i_funct7_b5) begin
                                o_cw.aluop = ctrl_pkg::alu_sra;
                            end else begin
                                o_cw.aluop = ctrl_pkg::alu_srl;
                            end
                        end
                        3'd6: o_cw.aluop = ctrl_pkg::alu_or;
                        default: o_cw.aluop = ctrl_pkg::alu_and;
                    endcase
                end
                default: begin
                    // illegal opcode leaves the idle word
                    o_cw.valid = 1'b0;
                end
            endcase
        end
    end

endmodule

// File: src/stall_ctrl.sv
`include "ctrl_config.svh"

module stall_ctrl (
    input  logic                        rst,
    input  logic [`CTRL_NUM_STAGES-1:0] i_valid,
    input  logic [`CTRL_NUM_STAGES-1:0] i_rdy,
    output logic [`CTRL_NUM_LD-1:0]     o_ld
);

    // stage index: 0 if, 1 de, 2 exe, 3 mem, 4 wb
    logic [`CTRL_NUM_STAGES-1:0] stall;
    // hold[s] is high when stage s or any later stage stalls
    logic [`CTRL_NUM_STAGES-1:0] hold;

    genvar s;
    for (s = 0; s < `CTRL_NUM_STAGES; s++) begin : g_stall
        // valid but still busy
        assign stall[s] = i_valid[s] & ~i_rdy[s];
        if (s == `CTRL_NUM_STAGES - 1) begin : g_last
            assign hold[s] = stall[s];
        end else begin : g_chain
            assign hold[s] = stall[s] | hold[s+1];
        end
    end

    // register k sits in front of stage k+1
    genvar k;
    for (k = 0; k < `CTRL_NUM_LD; k++) begin : g_ld
        assign o_ld[k] = ~rst & ~hold[k+1];
    end

endmodule

// File: src/cw_stage.sv
module cw_stage (
    input  logic          clk,
    input  logic          rst,
    input  logic          i_ld,
    input  logic          i_ld_up,
    input  ctrl_pkg::cw_t i_cw,
    output ctrl_pkg::cw_t o_cw
);

    // bubble: no flags, first value of each selector
    localparam ctrl_pkg::cw_t CW_IDLE = '{
        valid:          1'b0,
        aluop:          ctrl_pkg::alu_add,
        alumux1_sel:    ctrl_pkg::mux1_rs1_out,
        alumux2_sel:    ctrl_pkg::mux2_i_imm,
        cmpop:          ctrl_pkg::beq,
        cmp_sel:        ctrl_pkg::cmpmux_rs2_out,
        pc_kind:        ctrl_pkg::pc_seq,
        mem_read:       1'b0,
        mem_write:      1'b0,
        ld_reg:         1'b0,
        regfilemux_sel: ctrl_pkg::rf_alu_out,
        rd_addr:        '0
    };

    always_ff @(posedge clk) begin
        if (rst) begin
            o_cw <= CW_IDLE;
        end else if (i_ld) begin
            // upstream frozen, so its word stays there and a bubble moves on
            o_cw <= i_ld_up ? i_cw : CW_IDLE;
        end
    end

endmodule

// File: src/pc_select.sv
module pc_select (
    input  ctrl_pkg::pc_kind_e i_pc_kind,
    input  logic               i_valid,
    input  logic               i_br_en,
    output ctrl_pkg::pcmux_e   o_pcmux_sel
);

    always_comb begin
        o_pcmux_sel = ctrl_pkg::pcmux_pc_plus4;
        // a bubble in exe never redirects fetch
        if (i_valid) begin
            case (i_pc_kind)
                ctrl_pkg::pc_jal: o_pcmux_sel = ctrl_pkg::pcmux_alu_out;
                ctrl_pkg::pc_jalr: o_pcmux_sel = ctrl_pkg::pcmux_alu_mod2;
                ctrl_pkg::pc_branch: begin
                    // taken branch jumps to pc + b_imm
                    if (i_br_en) begin
                        o_pcmux_sel = ctrl_pkg::pcmux_alu_out;
                    end
                end
                default: o_pcmux_sel = ctrl_pkg::pcmux_pc_plus4;
            endcase
        end
    end

endmodule

// File: src/rv_ctrl_top.sv
`include "ctrl_config.svh"

module rv_ctrl_top (
    input  logic                      clk,
    input  logic                      rst,
    // de stage fields
    input  logic [`CTRL_OPCODE_W-1:0] i_opcode,
    input  logic [`CTRL_FUNCT3_W-1:0] i_funct3,
    input  logic                      i_funct7_b5,
    input  logic [`CTRL_REG_W-1:0]    i_rd_addr,
    // exe comparator result
    input  logic                      i_br_en,
    // stage handshake
    input  logic                      i_if_valid,
    input  logic                      i_de_valid,
    input  logic                      i_exe_valid,
    input  logic                      i_mem_valid,
    input  logic                      i_wb_valid,
    input  logic                      i_if_rdy,
    input  logic                      i_de_rdy,
    input  logic                      i_exe_rdy,
    input  logic                      i_mem_rdy,
    input  logic                      i_wb_rdy,
    // pipeline register enables
    output logic                      o_if_de_ld,
    output logic                      o_de_exe_ld,
    output logic                      o_exe_mem_ld,
    output logic                      o_mem_wb_ld,
    // exe slot
    output ctrl_pkg::alu_op_e         o_aluop,
    output ctrl_pkg::alumux1_e        o_alumux1_sel,
    output ctrl_pkg::alumux2_e        o_alumux2_sel,
    output ctrl_pkg::cmp_op_e         o_cmpop,
    output ctrl_pkg::cmpmux_e         o_cmp_sel,
    // mem slot
    output logic                      o_mem_read,
    output logic                      o_mem_write,
    // wb slot
    output logic                      o_ld_reg,
    output ctrl_pkg::regfilemux_e     o_regfilemux_sel,
    output logic [`CTRL_REG_W-1:0]    o_rd_addr,
    // fetch
    output ctrl_pkg::pcmux_e          o_pcmux_sel
);

    logic [`CTRL_NUM_STAGES-1:0] valid;
    logic [`CTRL_NUM_STAGES-1:0] rdy;
    logic [`CTRL_NUM_LD-1:0]     ld;
    // 0 decoder output, 1 exe, 2 mem, 3 wb
    ctrl_pkg::cw_t               cw_chain [`CTRL_NUM_LD];

    // bit 0 is if, bit 4 is wb
    assign valid = {i_wb_valid, i_mem_valid, i_exe_valid, i_de_valid, i_if_valid};
    assign rdy   = {i_wb_rdy, i_mem_rdy, i_exe_rdy, i_de_rdy, i_if_rdy};

    stall_ctrl u_stall (
        .rst     (rst),
        .i_valid (valid),
        .i_rdy   (rdy),
        .o_ld    (ld)
    );

    instr_decoder u_dec (
        .i_opcode    (i_opcode),
        .i_funct3    (i_funct3),
        .i_funct7_b5 (i_funct7_b5),
        .i_rd_addr   (i_rd_addr),
        .i_de_valid  (i_de_valid),
        .i_de_rdy    (i_de_rdy),
        .o_cw        (cw_chain[0])
    );

    // de/exe, exe/mem, mem/wb control word registers
    genvar g;
    for (g = 0; g < `CTRL_NUM_LD - 1; g++) begin : g_cw_stage
        cw_stage u_stage (
            .clk     (clk),
            .rst     (rst),
            .i_ld    (ld[g+1]),
            .i_ld_up (ld[g]),
            .i_cw    (cw_chain[g]),
            .o_cw    (cw_chain[g+1])
        );
    end

    pc_select u_pcsel (
        .i_pc_kind   (cw_chain[1].pc_kind),
        .i_valid     (cw_chain[1].valid),
        .i_br_en     (i_br_en),
        .o_pcmux_sel (o_pcmux_sel)
    );

    assign o_if_de_ld   = ld[0];
    assign o_de_exe_ld  = ld[1];
    assign o_exe_mem_ld = ld[2];
    assign o_mem_wb_ld  = ld[3];

    assign o_aluop       = cw_chain[1].aluop;
    assign o_alumux1_sel = cw_chain[1].alumux1_sel;
    assign o_alumux2_sel = cw_chain[1].alumux2_sel;
    assign o_cmpop       = cw_chain[1].cmpop;
    assign o_cmp_sel     = cw_chain[1].cmp_sel;

    assign o_mem_read  = cw_chain[2].mem_read;
    assign o_mem_write = cw_chain[2].mem_write;

    assign o_ld_reg         = cw_chain[3].ld_reg;
    assign o_regfilemux_sel = cw_chain[3].regfilemux_sel;
    assign o_rd_addr        = cw_chain[3].rd_addr;

endmodule

// File: sim/rv_ctrl_assert.sv
`include "ctrl_config.svh"

module rv_ctrl_assert (
    input logic                    clk,
    input logic                    rst,
    input logic [`CTRL_NUM_LD-1:0] i_ld,
    input logic                    i_mem_read,
    input logic                    i_mem_write
);

    // every pipeline register frozen in reset
    a_ld_reset: assert property (@(posedge clk) rst |-> (i_ld == '0))
        else $error("load enable high during reset");

    // a stall freezes all registers upstream of it
    genvar k;
    for (k = 1; k < `CTRL_NUM_LD; k++) begin : g_mono
        a_ld_mono: assert property (@(posedge clk) disable iff (rst) !i_ld[k] |-> !i_ld[k-1])
            else $error("load enable %0d high while enable %0d is low", k - 1, k);
    end

    // one memory access kind per slot
    a_mem_excl: assert property (@(posedge clk) disable iff (rst) !(i_mem_read && i_mem_write))
        else $error("mem_read and mem_write high together");

endmodule

bind rv_ctrl_top rv_ctrl_assert u_assert (
    .clk         (clk),
    .rst         (rst),
    .i_ld        ({o_mem_wb_ld, o_exe_mem_ld, o_de_exe_ld, o_if_de_ld}),
    .i_mem_read  (o_mem_read),
    .i_mem_write (o_mem_write)
);

// File: sim/tb_rv_ctrl.sv
`include "ctrl_config.svh"

module tb_rv_ctrl;

    // tests take about 400 cycles
    localparam int MAX_CYCLES = 2000;

    logic                      clk;
    logic                      rst;
    logic [`CTRL_OPCODE_W-1:0] i_opcode;
    logic [`CTRL_FUNCT3_W-1:0] i_funct3;
    logic                      i_funct7_b5;
    logic [`CTRL_REG_W-1:0]    i_rd_addr;
    logic                      i_br_en;
    logic                      i_if_valid, i_de_valid, i_exe_valid, i_mem_valid, i_wb_valid;
    logic                      i_if_rdy, i_de_rdy, i_exe_rdy, i_mem_rdy, i_wb_rdy;
    logic                      o_if_de_ld, o_de_exe_ld, o_exe_mem_ld, o_mem_wb_ld;
    ctrl_pkg::alu_op_e         o_aluop;
    ctrl_pkg::alumux1_e        o_alumux1_sel;
    ctrl_pkg::alumux2_e        o_alumux2_sel;
    ctrl_pkg::cmp_op_e         o_cmpop;
    ctrl_pkg::cmpmux_e         o_cmp_sel;
    logic                      o_mem_read, o_mem_write, o_ld_reg;
    ctrl_pkg::regfilemux_e     o_regfilemux_sel;
    logic [`CTRL_REG_W-1:0]    o_rd_addr;
    ctrl_pkg::pcmux_e          o_pcmux_sel;
    logic [`CTRL_NUM_LD-1:0]   ld_out;

    int     errors = 0;
    int     checks = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     cycle_count = 0;
    integer seed;

    rv_ctrl_top dut (
        .clk(clk), .rst(rst),
        .i_opcode(i_opcode), .i_funct3(i_funct3), .i_funct7_b5(i_funct7_b5),
        .i_rd_addr(i_rd_addr), .i_br_en(i_br_en),
        .i_if_valid(i_if_valid), .i_de_valid(i_de_valid), .i_exe_valid(i_exe_valid),
        .i_mem_valid(i_mem_valid), .i_wb_valid(i_wb_valid),
        .i_if_rdy(i_if_rdy), .i_de_rdy(i_de_rdy), .i_exe_rdy(i_exe_rdy),
        .i_mem_rdy(i_mem_rdy), .i_wb_rdy(i_wb_rdy),
        .o_if_de_ld(o_if_de_ld), .o_de_exe_ld(o_de_exe_ld),
        .o_exe_mem_ld(o_exe_mem_ld), .o_mem_wb_ld(o_mem_wb_ld),
        .o_aluop(o_aluop), .o_alumux1_sel(o_alumux1_sel), .o_alumux2_sel(o_alumux2_sel),
        .o_cmpop(o_cmpop), .o_cmp_sel(o_cmp_sel),
        .o_mem_read(o_mem_read), .o_mem_write(o_mem_write),
        .o_ld_reg(o_ld_reg), .o_regfilemux_sel(o_regfilemux_sel), .o_rd_addr(o_rd_addr),
        .o_pcmux_sel(o_pcmux_sel)
    );

    // bit k loads the register in front of stage k+1
    assign ld_out = {o_mem_wb_ld, o_exe_mem_ld, o_de_exe_ld, o_if_de_ld};

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    task automatic check(input logic [7:0] actual, input logic [7:0] expected,
                         input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at time %0t: %s: got %0h, expected %0h",
                     $time, msg, actual, expected);
        end
    endtask

    // step to just after the next rising edge
    task automatic tick;
        @(posedge clk);
        #1;
    endtask

    // let combinational outputs follow new inputs
    task automatic settle;
        #1;
    endtask

    task automatic set_handshake(input logic [4:0] valid, input logic [4:0] rdy);
        {i_wb_valid, i_mem_valid, i_exe_valid, i_de_valid, i_if_valid} = valid;
        {i_wb_rdy, i_mem_rdy, i_exe_rdy, i_de_rdy, i_if_rdy} = rdy;
    endtask

    task automatic drive_instr(input logic [6:0] op, input logic [2:0] f3, input logic f7,
                               input logic [4:0] rd);
        i_opcode    = op;
        i_funct3    = f3;
        i_funct7_b5 = f7;
        i_rd_addr   = rd;
    endtask

    // opcode 0 is illegal, so the decoder emits bubbles
    task automatic drive_idle;
        drive_instr(7'h00, 3'd0, 1'b0, 5'd0);
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    // register k loads unless a stage after it is valid and busy
    function automatic logic [3:0] expected_ld(input logic [4:0] valid, input logic [4:0] rdy);
        logic [3:0] ld;
        logic       blocked;
        int         s;
        blocked = 1'b0;
        for (s = 4; s >= 1; s--) begin
            blocked   = blocked | (valid[s] & ~rdy[s]);
            ld[s-1] = ~blocked;
        end
        return ld;
    endfunction

    // alu op for the non-compare imm and reg forms
    function automatic logic [7:0] expected_aluop(input logic is_reg, input logic [2:0] f3,
                                                  input logic f7);
        ctrl_pkg::alu_op_e e;
        case (f3)
            3'd0: e = (is_reg && f7) ? ctrl_pkg::alu_sub : ctrl_pkg::alu_add;
            3'd1: e = ctrl_pkg::alu_sll;
            3'd4: e = ctrl_pkg::alu_xor;
            3'd5: e = f7 ? ctrl_pkg::alu_sra : ctrl_pkg::alu_srl;
            3'd6: e = ctrl_pkg::alu_or;
            default: e = ctrl_pkg::alu_and;
        endcase
        return 8'(e);
    endfunction

    task automatic test_reset;
        int err_before;
        int i;
        err_before = errors;
        for (i = 0; i < 10; i++) begin
            tick;
            check(8'(ld_out), 8'h00, "load enables in reset");
            check(8'(o_mem_read), 8'h00, "mem_read in reset");
            check(8'(o_mem_write), 8'h00, "mem_write in reset");
            check(8'(o_ld_reg), 8'h00, "ld_reg in reset");
        end
        rst = 1'b0;
        // first edge out of reset moves the cleared exe and mem words down a slot
        tick;
        check(8'(o_mem_read), 8'h00, "mem_read after reset");
        check(8'(o_mem_write), 8'h00, "mem_write after reset");
        check(8'(o_ld_reg), 8'h00, "ld_reg after reset");
        check(8'(o_pcmux_sel), 8'(ctrl_pkg::pcmux_pc_plus4), "pcmux after reset");
        report_test("reset", err_before);
    endtask

    task automatic test_stall_rule;
        int          err_before;
        int          n;
        logic [31:0] r;
        err_before = errors;
        for (n = 0; n < 200; n++) begin
            tick;
            r = $random(seed);
            set_handshake(r[4:0], r[9:5]);
            settle;
            check(8'(ld_out), 8'(expected_ld(r[4:0], r[9:5])),
                  $sformatf("load enables valid=%b rdy=%b", r[4:0], r[9:5]));
        end
        set_handshake(5'h1f, 5'h1f);
        report_test("stall_rule", err_before);
    endtask

    task automatic test_alu_decode;
        int         err_before;
        int         op_i, f3, f7;
        logic       is_reg;
        logic [6:0] op;
        string      ctx;
        err_before = errors;
        for (op_i = 0; op_i < 2; op_i++) begin
            is_reg = op_i[0];
            op     = is_reg ? ctrl_pkg::op_reg : ctrl_pkg::op_imm;
            for (f3 = 0; f3 < 8; f3++) begin
                for (f7 = 0; f7 < 2; f7++) begin
                    ctx = $sformatf("op=%0h f3=%0d f7=%0d", op, f3, f7);
                    tick;
                    drive_instr(op, 3'(f3), 1'(f7), 5'(f3 * 2 + f7 + 1));
                    // exe slot one edge later
                    tick;
                    drive_idle;
                    settle;
                    check(8'(o_alumux1_sel), 8'(ctrl_pkg::mux1_rs1_out), {ctx, " alumux1"});
                    check(8'(o_alumux2_sel), is_reg ? 8'(ctrl_pkg::mux2_rs2_out)
                          : 8'(ctrl_pkg::mux2_i_imm), {ctx, " alumux2"});
                    if (f3 == 2 || f3 == 3) begin
                        // slt and sltu use the comparator
                        check(8'(o_cmpop), (f3 == 2) ? 8'(ctrl_pkg::blt) : 8'(ctrl_pkg::bltu),
                              {ctx, " cmpop"});
                        check(8'(o_cmp_sel), is_reg ? 8'(ctrl_pkg::cmpmux_rs2_out)
                              : 8'(ctrl_pkg::cmpmux_i_imm), {ctx, " cmp_sel"});
                    end else begin
                        check(8'(o_aluop), expected_aluop(is_reg, 3'(f3), 1'(f7)),
                              {ctx, " aluop"});
                    end
                    // wb slot three edges after decode
                    tick;
                    tick;
                    check(8'(o_ld_reg), 8'h01, {ctx, " ld_reg"});
                    check(8'(o_regfilemux_sel), (f3 == 2 || f3 == 3) ? 8'(ctrl_pkg::rf_br_en)
                          : 8'(ctrl_pkg::rf_alu_out), {ctx, " regfilemux"});
                    check(8'(o_rd_addr), 8'(f3 * 2 + f7 + 1), {ctx, " rd_addr"});
                end
            end
        end
        report_test("alu_decode", err_before);
    endtask

    task automatic mem_case(input logic [6:0] op, input logic [2:0] f3, input logic [4:0] rd,
                            input logic exp_read, input logic exp_write, input logic exp_ld,
                            input logic [7:0] exp_rfmux, input string name);
        tick;
        drive_instr(op, f3, 1'b0, rd);
        tick;
        drive_idle;
        // mem slot two edges after decode
        tick;
        check(8'(o_mem_read), 8'(exp_read), {name, " mem_read"});
        check(8'(o_mem_write), 8'(exp_write), {name, " mem_write"});
        tick;
        check(8'(o_ld_reg), 8'(exp_ld), {name, " ld_reg"});
        if (exp_ld) begin
            check(8'(o_regfilemux_sel), exp_rfmux, {name, " regfilemux"});
            check(8'(o_rd_addr), 8'(rd), {name, " rd_addr"});
        end
    endtask

    task automatic test_mem_decode;
        int err_before;
        err_before = errors;
        mem_case(ctrl_pkg::op_load, 3'd0, 5'd3, 1, 0, 1, 8'(ctrl_pkg::rf_lb), "lb");
        mem_case(ctrl_pkg::op_load, 3'd1, 5'd4, 1, 0, 1, 8'(ctrl_pkg::rf_lh), "lh");
        mem_case(ctrl_pkg::op_load, 3'd2, 5'd5, 1, 0, 1, 8'(ctrl_pkg::rf_lw), "lw");
        mem_case(ctrl_pkg::op_load, 3'd4, 5'd6, 1, 0, 1, 8'(ctrl_pkg::rf_lbu), "lbu");
        mem_case(ctrl_pkg::op_load, 3'd5, 5'd7, 1, 0, 1, 8'(ctrl_pkg::rf_lhu), "lhu");
        mem_case(ctrl_pkg::op_store, 3'd2, 5'd8, 0, 1, 0, 8'h00, "sw");
        mem_case(ctrl_pkg::op_lui, 3'd0, 5'd30, 0, 0, 1, 8'(ctrl_pkg::rf_u_imm), "lui");
        mem_case(ctrl_pkg::op_auipc, 3'd0, 5'd31, 0, 0, 1, 8'(ctrl_pkg::rf_alu_out), "auipc");
        report_test("mem_decode", err_before);
    endtask

    task automatic pc_case(input logic [6:0] op, input logic br_en, input logic [7:0] exp_sel,
                           input string name);
        tick;
        drive_instr(op, 3'd0, 1'b0, 5'd1);
        i_br_en = br_en;
        tick;
        drive_idle;
        settle;
        check(8'(o_pcmux_sel), exp_sel, {name, " pcmux"});
        // a bubble in exe falls back to pc+4
        tick;
        check(8'(o_pcmux_sel), 8'(ctrl_pkg::pcmux_pc_plus4), {name, " pcmux after"});
        i_br_en = 1'b0;
    endtask

    task automatic test_next_pc;
        int err_before;
        err_before = errors;
        pc_case(ctrl_pkg::op_br, 1'b0, 8'(ctrl_pkg::pcmux_pc_plus4), "branch not taken");
        pc_case(ctrl_pkg::op_br, 1'b1, 8'(ctrl_pkg::pcmux_alu_out), "branch taken");
        pc_case(ctrl_pkg::op_jal, 1'b0, 8'(ctrl_pkg::pcmux_alu_out), "jal");
        pc_case(ctrl_pkg::op_jalr, 1'b0, 8'(ctrl_pkg::pcmux_alu_mod2), "jalr");
        report_test("next_pc", err_before);
    endtask

    task automatic test_back_pressure;
        int err_before;
        int i;
        err_before = errors;
        tick;
        drive_instr(ctrl_pkg::op_load, 3'd2, 1'b0, 5'd9);
        tick;
        drive_idle;
        tick;
        check(8'(o_mem_read), 8'h01, "load in mem slot");
        // mem busy so only mem/wb may move
        i_mem_rdy = 1'b0;
        settle;
        check(8'(ld_out), 8'h08, "load enables with mem stalled");
        for (i = 0; i < 3; i++) begin
            tick;
            check(8'(o_mem_read), 8'h01, "mem slot holds");
            check(8'(o_ld_reg), 8'h00, "bubble into wb");
        end
        i_mem_rdy = 1'b1;
        settle;
        check(8'(ld_out), 8'h0f, "load enables after mem ready");
        tick;
        check(8'(o_ld_reg), 8'h01, "held load reaches wb");
        check(8'(o_regfilemux_sel), 8'(ctrl_pkg::rf_lw), "held load regfilemux");
        check(8'(o_rd_addr), 8'd9, "held load rd_addr");
        check(8'(o_mem_read), 8'h00, "mem slot empties");
        report_test("back_pressure", err_before);
    endtask

    initial begin
        rst  = 1'b1;
        seed = 32'h63bb;
        i_br_en = 1'b0;
        set_handshake(5'h1f, 5'h1f);
        drive_idle;
        test_reset;
        test_stall_rule;
        test_alu_decode;
        test_mem_decode;
        test_next_pc;
        test_back_pressure;
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+include
src/ctrl_pkg.sv
src/instr_decoder.sv
src/stall_ctrl.sv
src/cw_stage.sv
src/pc_select.sv
src/rv_ctrl_top.sv
sim/rv_ctrl_assert.sv
sim/tb_rv_ctrl.sv

// File: run.sh
#!/bin/sh
# build and run the control unit testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rv_ctrl -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_rv_ctrl)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Everything OK"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
